/* Bender.yml */
package:
  name: periph_soc

sources:
  # packages and the bus interface first
  - bus_pkg.sv
  - periph_pkg.sv
  - bus_if.sv
  - bus_arbiter.sv
  - bus_decoder.sv
  - scratch_ram.sv
  - periph_timer.sv
  - periph_gpio.sv
  - periph_soc.sv
  - target: simulation
    files:
      - periph_soc_checker.sv
      - tb_periph_soc.sv

/* bus_arbiter.sv */
// fixed priority arbiter for two masters where m0 always wins
// the losing master sees m1_hold_o and must keep its request up;
// a master that does not own the bus reads zero
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                          clk,
    input  logic                          rst_i,

    input  logic                          m0_req_i,
    input  logic                          m0_we_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0] m0_addr_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0] m0_wdata_i,
    output logic [bus_pkg::BUS_WIDTH-1:0] m0_rdata_o,

    input  logic                          m1_req_i,
    input  logic                          m1_we_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0] m1_addr_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0] m1_wdata_i,
    output logic [bus_pkg::BUS_WIDTH-1:0] m1_rdata_o,

    output logic                          m1_hold_o,
    bus_if.master                         granted_o
);
    logic       grant_m0;
    logic       grant_m1;

    assign grant_m0 = m0_req_i;
    assign grant_m1 = m1_req_i & ~m0_req_i;

    // conflict holds m1
    assign m1_hold_o = m0_req_i & m1_req_i;

    // ----------------------------------------
    // winner onto the granted segment
    // ----------------------------------------
    assign granted_o.req      = grant_m0 | grant_m1;
    assign granted_o.we       = grant_m0 ? m0_we_i : m1_we_i;
    assign granted_o.addr.raw = grant_m0 ? m0_addr_i : m1_addr_i;
    assign granted_o.wdata    = grant_m0 ? m0_wdata_i : m1_wdata_i;

    // read data back to the owner only
    assign m0_rdata_o = grant_m0 ? granted_o.rdata : '0;
    assign m1_rdata_o = grant_m1 ? granted_o.rdata : '0;

endmodule

/* bus_decoder.sv */
// address decoder, slave chosen by addr[31:28]
// unmapped codes see no req, so writes there are dropped,
// and the read data returned upstream is zero
`timescale 1ns/1ps

module bus_decoder (
    bus_if.slave  up_i,
    bus_if.master ram_o,
    bus_if.master tmr_o,
    bus_if.master gpio_o
);
    import bus_pkg::*;

    logic [SLV_SEL_W-1:0] slv_sel;

    assign slv_sel = up_i.addr.field.slv_sel;

    // ----------------------------------------
    // request gating, one slave at most
    // ----------------------------------------
    assign ram_o.req  = up_i.req & (slv_sel == SLV_RAM);
    assign tmr_o.req  = up_i.req & (slv_sel == SLV_TIMER);
    assign gpio_o.req = up_i.req & (slv_sel == SLV_GPIO);

    // shared fields fan out unchanged
    assign ram_o.we     = up_i.we;
    assign ram_o.addr   = up_i.addr;
    assign ram_o.wdata  = up_i.wdata;

    assign tmr_o.we     = up_i.we;
    assign tmr_o.addr   = up_i.addr;
    assign tmr_o.wdata  = up_i.wdata;

    assign gpio_o.we    = up_i.we;
    assign gpio_o.addr  = up_i.addr;
    assign gpio_o.wdata = up_i.wdata;

    // ----------------------------------------
    // read return mux
    // ----------------------------------------
    always_comb begin
        case (slv_sel)
            SLV_RAM:   up_i.rdata = ram_o.rdata;
            SLV_TIMER: up_i.rdata = tmr_o.rdata;
            SLV_GPIO:  up_i.rdata = gpio_o.rdata;
            default:   up_i.rdata = '0;
        endcase
    end

endmodule

/* bus_if.sv */
// one segment of the shared bus, plain req/we strobes
// no handshake; rdata is combinational and valid in the req cycle
`timescale 1ns/1ps

interface bus_if;
    import bus_pkg::*;

    logic                 req;
    logic                 we;
    bus_addr_u            addr;
    logic [BUS_WIDTH-1:0] wdata;
    logic [BUS_WIDTH-1:0] rdata;

    // requesting side
    modport master (
        output req, we, addr, wdata,
        input  rdata
    );

    // responding side
    modport slave (
        input  req, we, addr, wdata,
        output rdata
    );

endinterface

/* bus_pkg.sv */
// bus widths, slave address map and the address union
// address is byte based; slaves only decode the word offset
// byte lane bits are carried along but no sub-word access exists
package bus_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int BUS_WIDTH = 32;
    localparam int SLV_SEL_W = 4;
    localparam int OFFSET_W  = 26;
    localparam int BYTE_W    = 2;

    // slave codes, taken from addr[31:28]
    localparam logic [SLV_SEL_W-1:0] SLV_RAM   = 4'd0;
    localparam logic [SLV_SEL_W-1:0] SLV_TIMER = 4'd1;
    localparam logic [SLV_SEL_W-1:0] SLV_GPIO  = 4'd2;

    localparam int RAM_WORDS = 16;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);

    // ----------------------------------------
    // address views
    // ----------------------------------------
    typedef struct packed {
        logic [SLV_SEL_W-1:0] slv_sel;
        logic [OFFSET_W-1:0]  offset;
        logic [BYTE_W-1:0]    byte_off;
    } bus_addr_fields_t;

    // decoder reads slv_sel, slaves read offset
    typedef union packed {
        logic [BUS_WIDTH-1:0] raw;
        bus_addr_fields_t     field;
    } bus_addr_u;

endpackage

/* periph_gpio.sv */
// 16 pin GPIO with two mode bits per pin, pin n at mode[2n+1:2n]
// the mode word fills the whole bus width
// pins are split into in, out and oe buses; no pads in here
// GPIO_IN is sampled every clock so reads lag the pins by one cycle
`timescale 1ns/1ps

module periph_gpio (
    input  logic                            clk,
    input  logic                            rst_i,
    bus_if.slave                            bus_i,
    input  logic [periph_pkg::GPIO_PINS-1:0] pins_i,
    output logic [periph_pkg::GPIO_PINS-1:0] pins_o,
    output logic [periph_pkg::GPIO_PINS-1:0] oe_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [GPIO_MODE_W*GPIO_PINS-1:0] mode_q;
    logic [GPIO_PINS-1:0]             data_q;
    logic [GPIO_PINS-1:0]             in_q;
    logic [GPIO_PINS-1:0]             in_mask;

    logic                 wr_en;
    logic [REG_SEL_W-1:0] reg_sel;

    assign wr_en   = bus_i.req & bus_i.we;
    assign reg_sel = bus_i.addr.field.offset[REG_SEL_W-1:0];

    // per pin mode decode
    always_comb begin
        for (int p = 0; p < GPIO_PINS; p++) begin
            oe_o[p]    = (mode_q[GPIO_MODE_W*p +: GPIO_MODE_W] == GPIO_MODE_OUT);
            in_mask[p] = (mode_q[GPIO_MODE_W*p +: GPIO_MODE_W] == GPIO_MODE_IN);
        end
    end

    assign pins_o = data_q;

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode_q <= '0;
            data_q <= '0;
            in_q   <= '0;
        end else begin
            in_q <= pins_i;
            if (wr_en && reg_sel == GPIO_MODE) begin
                mode_q <= bus_i.wdata;
            end
            if (wr_en && reg_sel == GPIO_DATA) begin
                data_q <= bus_i.wdata[GPIO_PINS-1:0];
            end
        end
    end

    // non-input pins read back as zero
    always_comb begin
        case (reg_sel)
            GPIO_MODE: bus_i.rdata = mode_q;
            GPIO_DATA: bus_i.rdata = {{(BUS_WIDTH-GPIO_PINS){1'b0}}, data_q};
            GPIO_IN:   bus_i.rdata = {{(BUS_WIDTH-GPIO_PINS){1'b0}}, in_q & in_mask};
            default:   bus_i.rdata = '0;
        endcase
    end

endmodule

/* periph_pkg.sv */
// register map of the timer and GPIO slaves
// registers sit on word offsets; only the low offset bits are decoded,
// so each register block repeats through the slave's address window
package periph_pkg;

    // word select width inside a peripheral
    localparam int REG_SEL_W = 2;

    // ----------------------------------------
    // timer
    // ----------------------------------------
    localparam logic [REG_SEL_W-1:0] TMR_CTRL  = 2'd0;
    localparam logic [REG_SEL_W-1:0] TMR_COUNT = 2'd1;
    localparam logic [REG_SEL_W-1:0] TMR_CMP   = 2'd2;
    localparam logic [REG_SEL_W-1:0] TMR_STAT  = 2'd3;

    // control bits
    localparam int TMR_EN_BIT = 0;
    localparam int TMR_IE_BIT = 1;

    // ----------------------------------------
    // gpio
    // ----------------------------------------
    localparam logic [REG_SEL_W-1:0] GPIO_MODE = 2'd0;
    localparam logic [REG_SEL_W-1:0] GPIO_DATA = 2'd1;
    localparam logic [REG_SEL_W-1:0] GPIO_IN   = 2'd2;

    localparam int GPIO_PINS   = 16;
    localparam int GPIO_MODE_W = 2;

    localparam logic [GPIO_MODE_W-1:0] GPIO_MODE_OUT = 2'b01;
    localparam logic [GPIO_MODE_W-1:0] GPIO_MODE_IN  = 2'b10;

endpackage

/* periph_soc.f */
bus_pkg.sv
periph_pkg.sv
bus_if.sv
bus_arbiter.sv
bus_decoder.sv
scratch_ram.sv
periph_timer.sv
periph_gpio.sv
periph_soc.sv
periph_soc_checker.sv
tb_periph_soc.sv

/* periph_soc.sv */
// peripheral subsystem top, two masters onto RAM, timer and GPIO
// map by addr[31:28]: 0 RAM, 1 timer, 2 GPIO, others unmapped
// m1 must keep its request up while m1_hold_o is high
// reads are combinational, writes land on the next rising edge
`timescale 1ns/1ps

module periph_soc (
    input  logic                             clk,
    input  logic                             rst_i,

    // core data port
    input  logic                             m0_req_i,
    input  logic                             m0_we_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0]    m0_addr_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0]    m0_wdata_i,
    output logic [bus_pkg::BUS_WIDTH-1:0]    m0_rdata_o,

    // debug and loader port
    input  logic                             m1_req_i,
    input  logic                             m1_we_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0]    m1_addr_i,
    input  logic [bus_pkg::BUS_WIDTH-1:0]    m1_wdata_i,
    output logic [bus_pkg::BUS_WIDTH-1:0]    m1_rdata_o,

    output logic                             m1_hold_o,
    output logic                             timer_irq_o,

    input  logic [periph_pkg::GPIO_PINS-1:0] gpio_i,
    output logic [periph_pkg::GPIO_PINS-1:0] gpio_o,
    output logic [periph_pkg::GPIO_PINS-1:0] gpio_oe_o
);

    // ----------------------------------------
    // bus segments
    // ----------------------------------------
    bus_if granted_bus ();
    bus_if ram_bus ();
    bus_if tmr_bus ();
    bus_if gpio_bus ();

    bus_arbiter arbiter_inst (
        .clk        ( clk         ),
        .rst_i      ( rst_i       ),
        .m0_req_i   ( m0_req_i    ),
        .m0_we_i    ( m0_we_i     ),
        .m0_addr_i  ( m0_addr_i   ),
        .m0_wdata_i ( m0_wdata_i  ),
        .m0_rdata_o ( m0_rdata_o  ),
        .m1_req_i   ( m1_req_i    ),
        .m1_we_i    ( m1_we_i     ),
        .m1_addr_i  ( m1_addr_i   ),
        .m1_wdata_i ( m1_wdata_i  ),
        .m1_rdata_o ( m1_rdata_o  ),
        .m1_hold_o  ( m1_hold_o   ),
        .granted_o  ( granted_bus )
    );

    bus_decoder decoder_inst (
        .up_i   ( granted_bus ),
        .ram_o  ( ram_bus     ),
        .tmr_o  ( tmr_bus     ),
        .gpio_o ( gpio_bus    )
    );

    // ----------------------------------------
    // slaves
    // ----------------------------------------
    scratch_ram ram_inst (
        .clk   ( clk     ),
        .rst_i ( rst_i   ),
        .bus_i ( ram_bus )
    );

    periph_timer timer_inst (
        .clk   ( clk         ),
        .rst_i ( rst_i       ),
        .bus_i ( tmr_bus     ),
        .irq_o ( timer_irq_o )
    );

    periph_gpio gpio_inst (
        .clk    ( clk       ),
        .rst_i  ( rst_i     ),
        .bus_i  ( gpio_bus  ),
        .pins_i ( gpio_i    ),
        .pins_o ( gpio_o    ),
        .oe_o   ( gpio_oe_o )
    );

endmodule

/* periph_soc_checker.sv */
// concurrent assertions bound into periph_soc, ports only
// a failing assertion raises $error and bumps fail_cnt
// stat write detection assumes m0 is never held
`timescale 1ns/1ps

module periph_soc_checker (
    input logic                             clk,
    input logic                             rst_i,
    input logic                             m0_req_i,
    input logic                             m0_we_i,
    input logic [bus_pkg::BUS_WIDTH-1:0]    m0_addr_i,
    input logic                             m1_req_i,
    input logic                             m1_we_i,
    input logic [bus_pkg::BUS_WIDTH-1:0]    m1_addr_i,
    input logic                             m1_hold_o,
    input logic                             timer_irq_o,
    input logic [periph_pkg::GPIO_PINS-1:0] gpio_oe_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    int   fail_cnt = 0;
    logic m0_stat_wr;
    logic m1_stat_wr;

    // write to the timer status word by the granted master
    assign m0_stat_wr = m0_req_i & m0_we_i & (m0_addr_i[31:28] == SLV_TIMER)
                        & (m0_addr_i[3:2] == TMR_STAT);
    assign m1_stat_wr = m1_req_i & ~m0_req_i & m1_we_i & (m1_addr_i[31:28] == SLV_TIMER)
                        & (m1_addr_i[3:2] == TMR_STAT);

    // ----------------------------------------
    hold_only_on_conflict: assert property (@(posedge clk) disable iff (rst_i)
        m1_hold_o |-> (m0_req_i && m1_req_i))
        else begin
            $error("m1_hold_o high without two requests");
            fail_cnt++;
        end

    oe_low_after_reset: assert property (@(posedge clk)
        $fell(rst_i) |-> (gpio_oe_o == '0))
        else begin
            $error("gpio_oe_o not zero after reset");
            fail_cnt++;
        end

    irq_drops_after_clear: assert property (@(posedge clk) disable iff (rst_i)
        (m0_stat_wr || m1_stat_wr) |=> !timer_irq_o)
        else begin
            $error("timer_irq_o still high after status write");
            fail_cnt++;
        end

endmodule

bind periph_soc periph_soc_checker checker_inst (
    .clk         ( clk         ),
    .rst_i       ( rst_i       ),
    .m0_req_i    ( m0_req_i    ),
    .m0_we_i     ( m0_we_i     ),
    .m0_addr_i   ( m0_addr_i   ),
    .m1_req_i    ( m1_req_i    ),
    .m1_we_i     ( m1_we_i     ),
    .m1_addr_i   ( m1_addr_i   ),
    .m1_hold_o   ( m1_hold_o   ),
    .timer_irq_o ( timer_irq_o ),
    .gpio_oe_o   ( gpio_oe_o   )
);

/* periph_timer.sv */
// free running timer with compare, auto reload and sticky status
// status sets on compare match while enabled and clears on any write
// to TMR_STAT; a clear wins over a match on the same edge
// irq_o is status gated by the interrupt enable bit
`timescale 1ns/1ps

module periph_timer (
    input  logic clk,
    input  logic rst_i,
    bus_if.slave bus_i,
    output logic irq_o
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic [1:0]           ctrl_q;
    logic [BUS_WIDTH-1:0] count_q;
    logic [BUS_WIDTH-1:0] cmp_q;
    logic                 stat_q;

    logic                 wr_en;
    logic [REG_SEL_W-1:0] reg_sel;
    logic                 hit;

    assign wr_en   = bus_i.req & bus_i.we;
    assign reg_sel = bus_i.addr.field.offset[REG_SEL_W-1:0];
    assign hit     = (count_q == cmp_q);

    // ----------------------------------------
    // register updates
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_q  <= 2'b00;
            count_q <= '0;
            cmp_q   <= '0;
            stat_q  <= 1'b0;
        end else begin
            if (wr_en && reg_sel == TMR_CTRL) begin
                ctrl_q <= bus_i.wdata[1:0];
            end
            if (wr_en && reg_sel == TMR_CMP) begin
                cmp_q <= bus_i.wdata;
            end
            // bus write beats the increment
            if (wr_en && reg_sel == TMR_COUNT) begin
                count_q <= bus_i.wdata;
            end else if (ctrl_q[TMR_EN_BIT]) begin
                count_q <= hit ? '0 : count_q + 1'b1;
            end
            if (wr_en && reg_sel == TMR_STAT) begin
                stat_q <= 1'b0;
            end else if (ctrl_q[TMR_EN_BIT] && hit) begin
                stat_q <= 1'b1;
            end
        end
    end

    // read mux
    always_comb begin
        case (reg_sel)
            TMR_CTRL:  bus_i.rdata = {{(BUS_WIDTH-2){1'b0}}, ctrl_q};
            TMR_COUNT: bus_i.rdata = count_q;
            TMR_CMP:   bus_i.rdata = cmp_q;
            default:   bus_i.rdata = {{(BUS_WIDTH-1){1'b0}}, stat_q};
        endcase
    end

    assign irq_o = stat_q & ctrl_q[TMR_IE_BIT];

endmodule

/* scratch_ram.sv */
// 16 word scratch RAM built from flops, cleared by reset
// word index is the low offset bits, higher offsets alias
`timescale 1ns/1ps

module scratch_ram (
    input  logic clk,
    input  logic rst_i,
    bus_if.slave bus_i
);
    import bus_pkg::*;

    logic [BUS_WIDTH-1:0] mem_q [RAM_WORDS];
    logic [RAM_IDX_W-1:0] idx;

    assign idx = bus_i.addr.field.offset[RAM_IDX_W-1:0];

    // combinational read
    assign bus_i.rdata = mem_q[idx];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (bus_i.req && bus_i.we) begin
            mem_q[idx] <= bus_i.wdata;
        end
    end

endmodule

/* tb_periph_soc.sv */
// testbench for periph_soc, stands in for both bus masters
// stops at the first mismatch or timeout; timer count is not modeled
`timescale 1ns/1ps

module tb_periph_soc;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int HOLD_LIMIT = 8;
    localparam int IRQ_LIMIT  = 100;
    localparam int POLL_LIMIT = 40;

    logic        clk;
    logic        rst;
    logic        m0_req, m0_we, m1_req, m1_we, m1_hold, timer_irq;
    logic [31:0] m0_addr, m0_wdata, m0_rdata, m1_addr, m1_wdata, m1_rdata;
    logic [15:0] gpio_in, gpio_out, gpio_oe;

    // reference model state
    logic [31:0] ram_model [16];
    logic [31:0] mode_model, cmp_model;
    logic [15:0] data_model, pins_model;
    logic [1:0]  ctrl_model;
    logic        stat_model;
    integer      seed;

    periph_soc periph_soc_inst (
        .clk (clk), .rst_i (rst),
        .m0_req_i (m0_req), .m0_we_i (m0_we), .m0_addr_i (m0_addr),
        .m0_wdata_i (m0_wdata), .m0_rdata_o (m0_rdata),
        .m1_req_i (m1_req), .m1_we_i (m1_we), .m1_addr_i (m1_addr),
        .m1_wdata_i (m1_wdata), .m1_rdata_o (m1_rdata),
        .m1_hold_o (m1_hold), .timer_irq_o (timer_irq),
        .gpio_i (gpio_in), .gpio_o (gpio_out), .gpio_oe_o (gpio_oe)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_stop();
        $display("Finished with errors");
        $fatal(1, "stopped on first failure");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
            fail_stop();
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [31:0] make_addr(input logic [3:0] slv, input logic [25:0] off);
        return {slv, off, 2'b00};
    endfunction

    function automatic logic [15:0] pin_mask(input logic [31:0] mode, input logic [1:0] code);
        logic [15:0] m;
        for (int p = 0; p < 16; p++) begin
            m[p] = (mode[2*p +: 2] == code);
        end
        return m;
    endfunction

    function automatic logic [31:0] expect_read(input logic [31:0] addr);
        logic [31:0] val;
        val = '0;
        case (addr[31:28])
            SLV_RAM:   val = ram_model[addr[5:2]];
            SLV_TIMER: begin
                // count is never read back
                if (addr[3:2] == TMR_CTRL) val = {30'b0, ctrl_model};
                if (addr[3:2] == TMR_CMP)  val = cmp_model;
                if (addr[3:2] == TMR_STAT) val = {31'b0, stat_model};
            end
            SLV_GPIO: begin
                if (addr[3:2] == GPIO_MODE) val = mode_model;
                if (addr[3:2] == GPIO_DATA) val = {16'b0, data_model};
                if (addr[3:2] == GPIO_IN) begin
                    val = {16'b0, pins_model & pin_mask(mode_model, GPIO_MODE_IN)};
                end
            end
            default:   val = '0;
        endcase
        return val;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data);
        if (addr[31:28] == SLV_RAM) ram_model[addr[5:2]] = data;
        if (addr[31:28] == SLV_TIMER && addr[3:2] == TMR_CTRL) ctrl_model = data[1:0];
        if (addr[31:28] == SLV_TIMER && addr[3:2] == TMR_CMP)  cmp_model = data;
        if (addr[31:28] == SLV_TIMER && addr[3:2] == TMR_STAT) stat_model = 1'b0;
        if (addr[31:28] == SLV_GPIO && addr[3:2] == GPIO_MODE) mode_model = data;
        if (addr[31:28] == SLV_GPIO && addr[3:2] == GPIO_DATA) data_model = data[15:0];
    endtask

    // ----------------------------------------
    // master tasks, one transfer each
    // ----------------------------------------
    task automatic m0_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        m0_req   <= 1'b1;
        m0_we    <= we;
        m0_addr  <= addr;
        m0_wdata <= wdata;
        @(negedge clk);
        rdata = m0_rdata;
        @(posedge clk);
        m0_req <= 1'b0;
        m0_we  <= 1'b0;
        if (we) model_write(addr, wdata);
    endtask

    task automatic m1_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        m1_req   <= 1'b1;
        m1_we    <= we;
        m1_addr  <= addr;
        m1_wdata <= wdata;
        @(negedge clk);
        // request stays up while held
        while (m1_hold) begin
            waited++;
            if (waited > HOLD_LIMIT) begin
                $display("m1 was held longer than %0d cycles", HOLD_LIMIT);
                fail_stop();
            end
            @(negedge clk);
        end
        rdata = m1_rdata;
        @(posedge clk);
        m1_req <= 1'b0;
        m1_we  <= 1'b0;
        if (we) model_write(addr, wdata);
    endtask

    // assertion failures in the bound checker
    always @(negedge clk) begin
        if (periph_soc_inst.checker_inst.fail_cnt != 0) begin
            $display("an assertion in the bound checker failed");
            fail_stop();
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] data;
        int          waited;
        seed = 32'h89ce_42e2;
        rst = 1'b1;
        {m0_req, m0_we, m1_req, m1_we} = '0;
        {m0_addr, m0_wdata, m1_addr, m1_wdata} = '0;
        gpio_in = '0;
        for (int i = 0; i < 16; i++) ram_model[i] = '0;
        {mode_model, cmp_model, data_model, pins_model, ctrl_model, stat_model} = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // RAM round trip, written by m0, read by m1
        for (int i = 0; i < 16; i++) begin
            data = $random(seed);
            m0_access(1'b1, make_addr(SLV_RAM, i), data, rd);
        end
        for (int i = 0; i < 16; i++) begin
            m1_access(1'b0, make_addr(SLV_RAM, i), '0, rd);
            check_val("ram round trip", expect_read(make_addr(SLV_RAM, i)), rd);
        end

        // ----------------------------------------
        // arbitration, same word from both masters
        // ----------------------------------------
        fork
            m0_access(1'b1, make_addr(SLV_RAM, 5), 32'h0bad_0000, data);
            m1_access(1'b1, make_addr(SLV_RAM, 5), 32'h1234_5678, rd);
            begin
                @(posedge clk);
                @(negedge clk);
                check_val("arb hold", 32'd1, {31'b0, m1_hold});
            end
        join
        m0_access(1'b0, make_addr(SLV_RAM, 5), '0, rd);
        check_val("arb last writer", expect_read(make_addr(SLV_RAM, 5)), rd);

        // GPIO: pins 0-3 out, 4-7 in, rest off
        m0_access(1'b1, make_addr(SLV_GPIO, GPIO_MODE), 32'hff00_aa55, rd);
        data = $random(seed);
        m0_access(1'b1, make_addr(SLV_GPIO, GPIO_DATA), data, rd);
        @(negedge clk);
        check_val("gpio oe", {16'b0, pin_mask(mode_model, GPIO_MODE_OUT)}, {16'b0, gpio_oe});
        check_val("gpio out", {16'b0, data_model}, {16'b0, gpio_out});
        data = $random(seed);
        @(posedge clk);
        gpio_in <= data[15:0];
        pins_model = data[15:0];
        repeat (2) @(posedge clk);
        m1_access(1'b0, make_addr(SLV_GPIO, GPIO_IN), '0, rd);
        check_val("gpio in", expect_read(make_addr(SLV_GPIO, GPIO_IN)), rd);
        m1_access(1'b0, make_addr(SLV_GPIO, GPIO_MODE), '0, rd);
        check_val("gpio mode", expect_read(make_addr(SLV_GPIO, GPIO_MODE)), rd);

        // ----------------------------------------
        // timer interrupt
        // ----------------------------------------
        m0_access(1'b1, make_addr(SLV_TIMER, TMR_CMP), 32'd20, rd);
        m0_access(1'b1, make_addr(SLV_TIMER, TMR_CTRL), 32'd3, rd);
        waited = 0;
        @(negedge clk);
        while (!timer_irq) begin
            waited++;
            if (waited > IRQ_LIMIT) begin
                $display("timer interrupt did not rise within %0d cycles", IRQ_LIMIT);
                fail_stop();
            end
            @(negedge clk);
        end
        stat_model = 1'b1;
        m0_access(1'b0, make_addr(SLV_TIMER, TMR_STAT), '0, rd);
        check_val("timer stat set", expect_read(make_addr(SLV_TIMER, TMR_STAT)), rd);
        m0_access(1'b1, make_addr(SLV_TIMER, TMR_STAT), 32'd0, rd);
        @(negedge clk);
        check_val("irq after clear", 32'd0, {31'b0, timer_irq});
        // interrupt enable off, status still sets
        m0_access(1'b1, make_addr(SLV_TIMER, TMR_CTRL), 32'd1, rd);
        waited = 0;
        rd = '0;
        while (!rd[0]) begin
            waited++;
            if (waited > POLL_LIMIT) begin
                $display("timer status did not set while polling");
                fail_stop();
            end
            m0_access(1'b0, make_addr(SLV_TIMER, TMR_STAT), '0, rd);
            check_val("irq masked", 32'd0, {31'b0, timer_irq});
        end
        stat_model = 1'b1;
        check_val("timer stat masked", expect_read(make_addr(SLV_TIMER, TMR_STAT)), rd);

        // unmapped slave code 7
        data = $random(seed);
        m1_access(1'b1, make_addr(4'd7, 3), data, rd);
        m1_access(1'b0, make_addr(4'd7, 3), '0, rd);
        check_val("unmapped read", expect_read(make_addr(4'd7, 3)), rd);
        for (int i = 0; i < 16; i++) begin
            m0_access(1'b0, make_addr(SLV_RAM, i), '0, rd);
            check_val("ram after unmapped", expect_read(make_addr(SLV_RAM, i)), rd);
        end

        @(negedge clk);
        if (periph_soc_inst.checker_inst.fail_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("an assertion in the bound checker failed");
            fail_stop();
        end
    end

endmodule
